/* logic/cu_pkg.sv */
package cu_pkg;

    // fixed by the instruction format
    localparam int opcode_bits = 4;
    localparam int state_bits  = 6;
    localparam int instr_bits  = 16;

    // common fetch sequence
    localparam logic [state_bits-1:0] st_fetch1  = 6'd0;
    localparam logic [state_bits-1:0] st_fetch2  = 6'd1;
    localparam logic [state_bits-1:0] st_fetch3  = 6'd2;

    // first state of each execute routine
    localparam logic [state_bits-1:0] st_nop     = 6'd3;
    localparam logic [state_bits-1:0] st_mov     = 6'd4;
    localparam logic [state_bits-1:0] st_alt_mov = 6'd5;
    localparam logic [state_bits-1:0] st_ldr     = 6'd7;
    localparam logic [state_bits-1:0] st_alt_ldr = 6'd9;
    localparam logic [state_bits-1:0] st_str     = 6'd13;
    localparam logic [state_bits-1:0] st_alt_str = 6'd17;
    localparam logic [state_bits-1:0] st_cmp     = 6'd21;
    localparam logic [state_bits-1:0] st_b       = 6'd22;
    localparam logic [state_bits-1:0] st_bgt     = 6'd23;
    localparam logic [state_bits-1:0] st_blt     = 6'd24;
    localparam logic [state_bits-1:0] st_beq     = 6'd25;
    localparam logic [state_bits-1:0] st_add     = 6'd26;
    localparam logic [state_bits-1:0] st_sub     = 6'd28;
    localparam logic [state_bits-1:0] st_mul     = 6'd30;
    localparam logic [state_bits-1:0] st_lsr     = 6'd32;
    localparam logic [state_bits-1:0] st_and     = 6'd34;
    localparam logic [state_bits-1:0] st_or      = 6'd36;
    localparam logic [state_bits-1:0] st_mvn     = 6'd38;

    // opcode numbers
    localparam logic [opcode_bits-1:0] op_nop = 4'd0;
    localparam logic [opcode_bits-1:0] op_mov = 4'd1;
    localparam logic [opcode_bits-1:0] op_ldr = 4'd2;
    localparam logic [opcode_bits-1:0] op_str = 4'd3;
    localparam logic [opcode_bits-1:0] op_cmp = 4'd4;
    localparam logic [opcode_bits-1:0] op_b   = 4'd5;
    localparam logic [opcode_bits-1:0] op_bgt = 4'd6;
    localparam logic [opcode_bits-1:0] op_blt = 4'd7;
    localparam logic [opcode_bits-1:0] op_beq = 4'd8;
    localparam logic [opcode_bits-1:0] op_add = 4'd9;
    localparam logic [opcode_bits-1:0] op_sub = 4'd10;
    localparam logic [opcode_bits-1:0] op_mul = 4'd11;
    localparam logic [opcode_bits-1:0] op_lsr = 4'd12;
    localparam logic [opcode_bits-1:0] op_and = 4'd13;
    localparam logic [opcode_bits-1:0] op_or  = 4'd14;
    localparam logic [opcode_bits-1:0] op_mvn = 4'd15;

    typedef enum logic [2:0] {
        cond_none,
        cond_always,
        cond_gt,
        cond_lt,
        cond_eq
    } cond_t;

    // ALU function code, same number as the ALU opcode
    typedef logic [opcode_bits-1:0] alu_op_t;

    typedef struct packed {
        logic [opcode_bits-1:0] opcode;
        logic [1:0]             rsel;
        logic [1:0]             rd;
        logic [1:0]             rs;
        logic [1:0]             rt;
        logic [3:0]             pad;
    } reg_form_t;

    typedef struct packed {
        logic [opcode_bits-1:0] opcode;
        logic [1:0]             rsel;
        logic [1:0]             rd;
        logic [7:0]             imm;
    } imm_form_t;

    // same 16 bits, two views
    typedef union packed {
        reg_form_t reg_form;
        imm_form_t imm_form;
    } instr_t;

endpackage

/* logic/instr_register.sv */
module instr_register
    import cu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ir_load,
    input  logic [instr_bits-1:0]  mem_rdata,
    output logic [opcode_bits-1:0] opcode,
    output logic [1:0]             rsel,
    output logic [1:0]             rd,
    output logic [1:0]             rs,
    output logic [1:0]             rt,
    output logic [7:0]             imm
);

    // fetched instruction word
    instr_t ir;

    // loads on the edge that ends fetch2
    always_ff @(posedge clk) begin
        if (rst) begin
            ir <= '0;
        end else if (ir_load) begin
            ir <= instr_t'(mem_rdata);
        end
    end

    // header fields sit at the same place in both forms
    always_comb begin
        opcode = ir.reg_form.opcode;
        rsel   = ir.reg_form.rsel;
        rd     = ir.reg_form.rd;
    end

    // register form
    // source and second source register
    always_comb begin
        rs = ir.reg_form.rs;
        rt = ir.reg_form.rt;
    end

    // immediate form
    // low byte of the word, overlaps rs, rt and pad
    always_comb begin
        imm = ir.imm_form.imm;
    end

endmodule

/* logic/cu_counter.sv */
module cu_counter
    import cu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [opcode_bits-1:0] opcode,
    input  logic [1:0]             sel_bits,
    input  logic                   load,
    input  logic                   inc,
    input  logic                   clr,
    output logic [state_bits-1:0]  q
);

    // opcode of the routine being run
    logic [opcode_bits-1:0] opcode_reg;
    // dispatch target for the incoming opcode
    logic [state_bits-1:0]  start_state;
    // last state belonging to the running opcode
    logic [state_bits-1:0]  last_state;

    // opcode to start state
    // sel bit 0 picks the alternate mov / ldr / str routine
    always_comb begin
        case (opcode)
            op_nop: start_state = st_nop;
            op_mov: start_state = sel_bits[0] ? st_alt_mov : st_mov;
            op_ldr: start_state = sel_bits[0] ? st_alt_ldr : st_ldr;
            op_str: start_state = sel_bits[0] ? st_alt_str : st_str;
            op_cmp: start_state = st_cmp;
            op_b:   start_state = st_b;
            op_bgt: start_state = st_bgt;
            op_blt: start_state = st_blt;
            op_beq: start_state = st_beq;
            op_add: start_state = st_add;
            op_sub: start_state = st_sub;
            op_mul: start_state = st_mul;
            op_lsr: start_state = st_lsr;
            op_and: start_state = st_and;
            op_or:  start_state = st_or;
            default: start_state = st_mvn;
        endcase
    end

    // upper end of each opcode's block of states
    // both forms of mov, ldr, str share one block
    always_comb begin
        case (opcode_reg)
            op_nop: last_state = st_nop;
            op_mov: last_state = st_alt_mov + 6'd1;
            op_ldr: last_state = st_alt_ldr + 6'd3;
            op_str: last_state = st_alt_str + 6'd3;
            op_cmp: last_state = st_cmp;
            op_b:   last_state = st_b;
            op_bgt: last_state = st_bgt;
            op_blt: last_state = st_blt;
            op_beq: last_state = st_beq;
            op_add: last_state = st_add + 6'd1;
            op_sub: last_state = st_sub + 6'd1;
            op_mul: last_state = st_mul + 6'd1;
            op_lsr: last_state = st_lsr + 6'd1;
            op_and: last_state = st_and + 6'd1;
            op_or:  last_state = st_or + 6'd1;
            default: last_state = st_mvn + 6'd1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            q          <= st_fetch1;
            opcode_reg <= op_nop;
        end else if (clr) begin
            // end of routine, back to fetch
            q          <= st_fetch1;
            opcode_reg <= op_nop;
        end else begin
            case ({load, inc})
                2'b10: begin
                    q          <= start_state;
                    opcode_reg <= opcode;
                end
                2'b01: begin
                    // never step out of the opcode's own block
                    // fetch states lie below every block so they always step
                    if (q == last_state) begin
                        q <= st_fetch1;
                    end else begin
                        q <= q + 6'd1;
                    end
                end
                // both or neither: hold
                default: begin
                    q <= q;
                end
            endcase
        end
    end

endmodule

/* logic/micro_rom.sv */
module micro_rom
    import cu_pkg::*;
(
    input  logic [state_bits-1:0]  state,
    input  logic [opcode_bits-1:0] opcode,
    output logic                   dispatch,
    output logic                   inc,
    output logic                   seq_end,
    output logic                   ir_load,
    output logic                   mar_load,
    output logic                   mar_src_pc,
    output logic                   mem_read,
    output logic                   mem_write,
    output logic                   mdr_load,
    output logic                   reg_write,
    output logic                   alu_src_imm,
    output alu_op_t                alu_op,
    output logic                   pc_inc,
    output logic                   flags_load,
    output cond_t                  branch_cond
);

    always_comb begin
        // all strobes idle unless the state asks
        dispatch    = 1'b0;
        seq_end     = 1'b0;
        ir_load     = 1'b0;
        mar_load    = 1'b0;
        mar_src_pc  = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mdr_load    = 1'b0;
        reg_write   = 1'b0;
        alu_src_imm = 1'b0;
        alu_op      = '0;
        pc_inc      = 1'b0;
        flags_load  = 1'b0;
        branch_cond = cond_none;

        case (state)
            // fetch: pc to mar, read word into ir, decode
            st_fetch1: begin
                mar_load   = 1'b1;
                mar_src_pc = 1'b1;
            end
            st_fetch2: begin
                mem_read = 1'b1;
                ir_load  = 1'b1;
                pc_inc   = 1'b1;
            end
            st_fetch3: begin
                dispatch = 1'b1;
            end

            st_nop: begin
                seq_end = 1'b1;
            end

            // register move
            st_mov: begin
                reg_write = 1'b1;
                seq_end   = 1'b1;
            end
            // immediate move, one extra cycle through the alu
            st_alt_mov: begin
                alu_src_imm = 1'b1;
            end
            st_alt_mov + 6'd1: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                seq_end     = 1'b1;
            end

            // load, address from register
            st_ldr: begin
                mar_load = 1'b1;
            end
            st_ldr + 6'd1: begin
                mem_read  = 1'b1;
                reg_write = 1'b1;
                seq_end   = 1'b1;
            end
            // load, address from immediate, data goes through mdr
            st_alt_ldr: begin
                mar_load    = 1'b1;
                alu_src_imm = 1'b1;
            end
            st_alt_ldr + 6'd1: begin
                mem_read = 1'b1;
            end
            st_alt_ldr + 6'd2: begin
                mdr_load = 1'b1;
            end
            st_alt_ldr + 6'd3: begin
                reg_write = 1'b1;
                seq_end   = 1'b1;
            end

            // store, two address forms then a shared tail
            st_str: begin
                mar_load = 1'b1;
            end
            st_alt_str: begin
                mar_load    = 1'b1;
                alu_src_imm = 1'b1;
            end
            st_str + 6'd1, st_alt_str + 6'd1: begin
                mdr_load = 1'b1;
            end
            st_str + 6'd2, st_alt_str + 6'd2: begin
                mem_write = 1'b1;
            end
            st_str + 6'd3, st_alt_str + 6'd3: begin
                seq_end = 1'b1;
            end

            st_cmp: begin
                flags_load = 1'b1;
                seq_end    = 1'b1;
            end

            // branches, taken or not decided in status_flags
            st_b: begin
                branch_cond = cond_always;
                seq_end     = 1'b1;
            end
            st_bgt: begin
                branch_cond = cond_gt;
                seq_end     = 1'b1;
            end
            st_blt: begin
                branch_cond = cond_lt;
                seq_end     = 1'b1;
            end
            st_beq: begin
                branch_cond = cond_eq;
                seq_end     = 1'b1;
            end

            // alu ops: operate, then write back
            st_add, st_sub, st_mul, st_lsr, st_and, st_or, st_mvn: begin
                alu_op = opcode;
            end
            st_add + 6'd1, st_sub + 6'd1, st_mul + 6'd1, st_lsr + 6'd1,
            st_and + 6'd1, st_or + 6'd1, st_mvn + 6'd1: begin
                alu_op    = opcode;
                reg_write = 1'b1;
                seq_end   = 1'b1;
            end

            // unused states 40..63 fall back to fetch
            default: begin
                seq_end = 1'b1;
            end
        endcase

        // step unless dispatching or finishing
        inc = !(dispatch || seq_end);
    end

endmodule

/* logic/status_flags.sv */
module status_flags
    import cu_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  flags_load,
    input  logic  alu_gt,
    input  logic  alu_lt,
    input  logic  alu_eq,
    input  cond_t branch_cond,
    output logic  pc_load,
    output logic  flag_gt,
    output logic  flag_lt,
    output logic  flag_eq
);

    // comparison result of the last cmp
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_gt <= 1'b0;
            flag_lt <= 1'b0;
            flag_eq <= 1'b0;
        end else if (flags_load) begin
            flag_gt <= alu_gt;
            flag_lt <= alu_lt;
            flag_eq <= alu_eq;
        end
    end

    // branch decision from stored flags only
    always_comb begin
        case (branch_cond)
            cond_always: pc_load = 1'b1;
            cond_gt:     pc_load = flag_gt;
            cond_lt:     pc_load = flag_lt;
            cond_eq:     pc_load = flag_eq;
            default:     pc_load = 1'b0;
        endcase
    end

endmodule

/* logic/control_unit_top.sv */
module control_unit_top
    import cu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [instr_bits-1:0]  mem_rdata,
    input  logic                   alu_gt,
    input  logic                   alu_lt,
    input  logic                   alu_eq,
    output logic [state_bits-1:0]  state,
    output logic [1:0]             rd,
    output logic [1:0]             rs,
    output logic [1:0]             rt,
    output logic [7:0]             imm,
    output logic                   mar_load,
    output logic                   mar_src_pc,
    output logic                   mem_read,
    output logic                   mem_write,
    output logic                   mdr_load,
    output logic                   reg_write,
    output logic                   alu_src_imm,
    output logic [opcode_bits-1:0] alu_op,
    output logic                   pc_inc,
    output logic                   pc_load,
    output logic                   flag_gt,
    output logic                   flag_lt,
    output logic                   flag_eq
);

    // ir to counter and rom
    logic [opcode_bits-1:0] opcode;
    logic [1:0]             rsel;
    // rom to counter
    logic                   dispatch;
    logic                   inc;
    logic                   seq_end;
    // rom to ir and flags
    logic                   ir_load;
    logic                   flags_load;
    cond_t                  branch_cond;

    instr_register ir_i (
        .clk       (clk),
        .rst       (rst),
        .ir_load   (ir_load),
        .mem_rdata (mem_rdata),
        .opcode    (opcode),
        .rsel      (rsel),
        .rd        (rd),
        .rs        (rs),
        .rt        (rt),
        .imm       (imm)
    );

    cu_counter counter_i (
        .clk      (clk),
        .rst      (rst),
        .opcode   (opcode),
        .sel_bits (rsel),
        .load     (dispatch),
        .inc      (inc),
        .clr      (seq_end),
        .q        (state)
    );

    micro_rom rom_i (
        .state       (state),
        .opcode      (opcode),
        .dispatch    (dispatch),
        .inc         (inc),
        .seq_end     (seq_end),
        .ir_load     (ir_load),
        .mar_load    (mar_load),
        .mar_src_pc  (mar_src_pc),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mdr_load    (mdr_load),
        .reg_write   (reg_write),
        .alu_src_imm (alu_src_imm),
        .alu_op      (alu_op),
        .pc_inc      (pc_inc),
        .flags_load  (flags_load),
        .branch_cond (branch_cond)
    );

    status_flags flags_i (
        .clk         (clk),
        .rst         (rst),
        .flags_load  (flags_load),
        .alu_gt      (alu_gt),
        .alu_lt      (alu_lt),
        .alu_eq      (alu_eq),
        .branch_cond (branch_cond),
        .pc_load     (pc_load),
        .flag_gt     (flag_gt),
        .flag_lt     (flag_lt),
        .flag_eq     (flag_eq)
    );

endmodule

/* testbench/control_unit_properties.sv */
module control_unit_properties
    import cu_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic [state_bits-1:0] state,
    input logic                  mem_read,
    input logic                  mem_write,
    input logic                  reg_write,
    input logic                  pc_inc
);

    // single memory port, read or write
    no_read_and_write: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write high in the same cycle");

    // states 40..63 are never entered
    state_in_range: assert property (@(posedge clk) disable iff (rst)
        state < 6'd40)
        else $error("state counter outside the microcode table");

    // dispatch always lands in a routine
    dispatch_leaves_fetch: assert property (@(posedge clk) disable iff (rst)
        state == st_fetch3 |=> state >= st_nop)
        else $error("state after fetch3 is still a fetch state");

    // write back never overlaps the pc step of fetch
    no_write_during_fetch: assert property (@(posedge clk) disable iff (rst)
        !(reg_write && pc_inc))
        else $error("reg_write and pc_inc high in the same cycle");

endmodule

bind control_unit_top control_unit_properties props_i (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .reg_write (reg_write),
    .pc_inc    (pc_inc)
);

/* testbench/control_unit_tb.sv */
module control_unit_tb
    import cu_pkg::*;
();

    logic        clk;
    logic        rst;
    logic [15:0] mem_rdata;
    logic        alu_gt;
    logic        alu_lt;
    logic        alu_eq;
    logic [5:0]  state;
    logic [1:0]  rd;
    logic [1:0]  rs;
    logic [1:0]  rt;
    logic [7:0]  imm;
    logic        mar_load;
    logic        mar_src_pc;
    logic        mem_read;
    logic        mem_write;
    logic        mdr_load;
    logic        reg_write;
    logic        alu_src_imm;
    logic [3:0]  alu_op;
    logic        pc_inc;
    logic        pc_load;
    logic        flag_gt;
    logic        flag_lt;
    logic        flag_eq;

    // seven fields per golden line, room for 32 lines
    logic [15:0] golden [0:7*32-1];
    // word waiting on mem_rdata for the next fetch
    logic [15:0] next_word;
    // gt, lt, eq as stored by the last cmp
    logic [2:0]  exp_flags;
    int          seed;
    int          limit_cycles = 0;
    int          line;

    control_unit_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .mem_rdata   (mem_rdata),
        .alu_gt      (alu_gt),
        .alu_lt      (alu_lt),
        .alu_eq      (alu_eq),
        .state       (state),
        .rd          (rd),
        .rs          (rs),
        .rt          (rt),
        .imm         (imm),
        .mar_load    (mar_load),
        .mar_src_pc  (mar_src_pc),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mdr_load    (mdr_load),
        .reg_write   (reg_write),
        .alu_src_imm (alu_src_imm),
        .alu_op      (alu_op),
        .pc_inc      (pc_inc),
        .pc_load     (pc_load),
        .flag_gt     (flag_gt),
        .flag_lt     (flag_lt),
        .flag_eq     (flag_eq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string what, input logic [31:0] got,
                         input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, expected);
            $display("TEST FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    // outputs settle, inputs change one unit after the edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    // words with no immediate: nop, cmp, alu ops, base mov/ldr/str
    function automatic logic is_reg_form(input logic [15:0] word);
        logic [3:0] op;
        op = word[15:12];
        if (op == op_mov || op == op_ldr || op == op_str) begin
            return !word[10];
        end
        return (op == op_nop || op == op_cmp || op >= op_add);
    endfunction

    // mdr_load cycles of one routine
    // alternate ldr and both str forms go through mdr
    function automatic int expected_mdr_loads(input logic [15:0] word);
        logic [3:0] op;
        op = word[15:12];
        if (op == op_str || (op == op_ldr && word[10])) begin
            return 1;
        end
        return 0;
    endfunction

    // alu_src_imm cycles, immediate forms of mov, ldr, str only
    function automatic int expected_imm_selects(input logic [15:0] word);
        logic [3:0] op;
        op = word[15:12];
        if (!word[10]) begin
            return 0;
        end
        if (op == op_mov) begin
            return 2;
        end
        if (op == op_ldr || op == op_str) begin
            return 1;
        end
        return 0;
    endfunction

    task automatic present_line(input int idx);
        logic [15:0] word;
        logic [15:0] flags;
        word  = golden[idx*7];
        flags = golden[idx*7 + 1];
        // pad bits are don't care in the register form
        if (is_reg_form(word)) begin
            word[3:0] = 4'($random(seed));
        end
        next_word = word;
        mem_rdata = word;
        alu_gt    = flags[2];
        alu_lt    = flags[1];
        alu_eq    = flags[0];
    endtask

    // entered in fetch2, returns in the next fetch2
    task automatic run_instruction(input int idx);
        logic [15:0] word;
        logic [3:0]  op;
        logic [3:0]  exp_alu;
        int          cycles;
        int          n_reg_write;
        int          n_mem_write;
        int          n_pc_load;
        int          n_mdr_load;
        int          n_imm_sel;
        word        = next_word;
        op          = word[15:12];
        cycles      = 0;
        n_reg_write = 0;
        n_mem_write = 0;
        n_pc_load   = 0;
        n_mdr_load  = 0;
        n_imm_sel   = 0;
        check("state at instruction start", 32'(state), 32'(st_fetch2));
        check("ir_load in fetch2", 32'(mem_read), 32'd1);
        do begin
            cycles++;
            if (reg_write) n_reg_write++;
            if (mem_write) n_mem_write++;
            if (pc_load) n_pc_load++;
            if (mdr_load) n_mdr_load++;
            if (alu_src_imm) n_imm_sel++;
            // ir holds the new word from fetch3 on
            if (cycles == 2) begin
                check("state in fetch3", 32'(state), 32'(st_fetch3));
                check("rd field", 32'(rd), 32'(word[9:8]));
                check("rs field", 32'(rs), 32'(word[7:6]));
                check("rt field", 32'(rt), 32'(word[5:4]));
                check("imm field", 32'(imm), 32'(word[7:0]));
            end
            if (cycles == 3) begin
                check("start state", 32'(state), 32'(golden[idx*7 + 6]));
            end
            // alu code only inside an alu routine
            exp_alu = 4'd0;
            if (cycles >= 3 && state != st_fetch1 && op >= op_add) begin
                exp_alu = op;
            end
            check("alu_op", 32'(alu_op), 32'(exp_alu));
            if (state == st_fetch1) begin
                present_line(idx + 1);
            end
            step_cycle();
        end while (state != st_fetch2);
        check("cycle count", 32'(cycles), 32'(golden[idx*7 + 2]));
        check("reg_write count", 32'(n_reg_write), 32'(golden[idx*7 + 3]));
        check("mem_write count", 32'(n_mem_write), 32'(golden[idx*7 + 4]));
        check("pc_load count", 32'(n_pc_load), 32'(golden[idx*7 + 5]));
        check("mdr_load count", 32'(n_mdr_load), 32'(expected_mdr_loads(word)));
        check("alu_src_imm count", 32'(n_imm_sel), 32'(expected_imm_selects(word)));
        // only cmp rewrites the stored flags
        if (op == op_cmp) begin
            exp_flags = golden[idx*7 + 1][2:0];
        end
        check("flag_gt", 32'(flag_gt), 32'(exp_flags[2]));
        check("flag_lt", 32'(flag_lt), 32'(exp_flags[1]));
        check("flag_eq", 32'(flag_eq), 32'(exp_flags[0]));
    endtask

    // ends a run that stops making progress
    initial begin
        wait (limit_cycles > 0);
        #(limit_cycles * 4);
        $display("timeout: golden list not finished after %0d cycles", limit_cycles);
        $display("TEST FAILED");
        $fatal(1, "watchdog");
    end

    initial begin
        rst       = 1'b1;
        mem_rdata = 16'h0000;
        alu_gt    = 1'b0;
        alu_lt    = 1'b0;
        alu_eq    = 1'b0;
        next_word = 16'h0000;
        exp_flags = 3'b000;
        seed      = 32'h722f;
        $readmemh("testbench/control_unit_golden.txt", golden);
        if (golden[2] == 16'h0000) begin
            $display("golden file holds no instructions");
            $display("TEST FAILED");
            $fatal(1, "empty stimulus");
        end

        // reset, fetch cycles and margin on top of the listed cycles
        line = 0;
        limit_cycles = 8 + 2 + 20;
        while (line < $size(golden) / 7 && golden[line*7 + 2] != 16'h0000) begin
            limit_cycles += int'(golden[line*7 + 2]);
            line++;
        end

        // held in fetch1 with memory writes off
        repeat (8) begin
            step_cycle();
            check("state in reset", 32'(state), 32'(st_fetch1));
            check("mem_write in reset", 32'(mem_write), 32'd0);
            check("reg_write in reset", 32'(reg_write), 32'd0);
            check("pc_load in reset", 32'(pc_load), 32'd0);
            check("pc_inc in reset", 32'(pc_inc), 32'd0);
            check("mar_load in reset", 32'(mar_load), 32'd1);
            check("mar_src_pc in reset", 32'(mar_src_pc), 32'd1);
        end
        rst = 1'b0;

        // first fetch1 after reset
        line = 0;
        present_line(line);
        step_cycle();
        while (line < $size(golden) / 7 - 1 && golden[line*7 + 2] != 16'h0000) begin
            run_instruction(line);
            line++;
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* testbench/control_unit_golden.txt */
// word flags(gt,lt,eq) cycles reg_write mem_write pc_load start_state
// all fields hex, one instruction per line; a line with cycles 0 ends the list
0000 0 04 0 0 0 03
1240 0 04 1 0 0 04
175a 0 05 1 0 0 05
2180 0 05 1 0 0 07
243c 0 07 1 0 0 09
32c0 0 07 0 1 0 0d
3da5 0 07 0 1 0 11
1890 0 04 1 0 0 04
6000 7 04 0 0 0 17
4060 4 04 0 0 0 15
6000 0 04 0 0 1 17
7000 0 04 0 0 0 18
8000 0 04 0 0 0 19
5000 0 04 0 0 1 16
4090 2 04 0 0 0 15
7000 5 04 0 0 1 18
6000 0 04 0 0 0 17
40a0 1 04 0 0 0 15
8000 6 04 0 0 1 19
91b0 0 05 1 0 0 1a
a210 0 05 1 0 0 1c
b350 0 05 1 0 0 1e
c0c0 0 05 1 0 0 20
d160 0 05 1 0 0 22
e2b0 0 05 1 0 0 24
f700 0 05 1 0 0 26
0000 0 00 0 0 0 00

/* files.f */
logic/cu_pkg.sv
logic/instr_register.sv
logic/cu_counter.sv
logic/micro_rom.sv
logic/status_flags.sv
logic/control_unit_top.sv
testbench/control_unit_properties.sv
testbench/control_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the control unit testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module control_unit_tb \
    -o control_unit_sim > sim.log 2>&1 \
    && ./obj_dir/control_unit_sim >> sim.log 2>&1 \
    || echo "build or simulation ended with an error" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log && { echo "simulation passed"; exit 0; } \
    || { echo "no pass line in log, counted as failure"; exit 1; }
